// ==== vregunpack.f ====
rtl/vregunpack_pkg.sv
rtl/unpack_stage_ctrl.sv
rtl/elem_operand_unpack.sv
rtl/mask_operand_unpack.sv
rtl/vregunpack_top.sv
sim/vregunpack_asserts.sv
sim/vregunpack_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the vregunpack testbench with Verilator, run it and judge the log

rm -f sim.log

verilator --binary --timing --assert --top-module vregunpack_tb \
    -f vregunpack.f -o vregunpack_sim \
    && ./obj_dir/vregunpack_sim | tee sim.log

grep -q "^No errors$" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// ==== sim/vregunpack_tb.sv ====
`timescale 1ns/100ps
// vregunpack testbench
// directed and random requests against a register file model, with every
// response compared to a reference model of the unpack rules
module vregunpack_tb;

    localparam int unsigned CLK_PERIOD = 20;
    localparam int unsigned NUM_RANDOM = 200;
    localparam int unsigned NUM_REQ    = NUM_RANDOM + 38;

    typedef struct packed {
        vregunpack_pkg::unpack_resp_t resp;
        logic [31:0]                  cycle;
        logic                         check_lat;
    } expect_t;

    logic                         clk_i;
    logic                         async_rst_ni;
    logic                         pipe_in_valid_i;
    logic                         pipe_in_ready_o;
    vregunpack_pkg::unpack_req_t  pipe_in_req_i;
    logic                         pipe_out_valid_o;
    logic                         pipe_out_ready_i;
    vregunpack_pkg::unpack_resp_t pipe_out_resp_o;
    vregunpack_pkg::vreg_addr_t   vreg_a_addr_o;
    vregunpack_pkg::vreg_data_t   vreg_a_data_i;
    vregunpack_pkg::vreg_addr_t   vreg_m_addr_o;
    vregunpack_pkg::vreg_data_t   vreg_m_data_i;

    vregunpack_pkg::vreg_data_t regfile [32];
    vregunpack_pkg::vreg_data_t ref_a_buf;
    vregunpack_pkg::vreg_data_t ref_m_buf;
    expect_t                    expected [$];
    logic [31:0]                cycle;
    logic [31:0]                stim_rnd;
    logic [7:0]                 sent;
    logic                       random_ready;
    logic                       fixed_ready;

    vregunpack_top vregunpack_top_inst (
        .clk_i            (clk_i),
        .async_rst_ni     (async_rst_ni),
        .pipe_in_valid_i  (pipe_in_valid_i),
        .pipe_in_ready_o  (pipe_in_ready_o),
        .pipe_in_req_i    (pipe_in_req_i),
        .pipe_out_valid_o (pipe_out_valid_o),
        .pipe_out_ready_i (pipe_out_ready_i),
        .pipe_out_resp_o  (pipe_out_resp_o),
        .vreg_a_addr_o    (vreg_a_addr_o),
        .vreg_a_data_i    (vreg_a_data_i),
        .vreg_m_addr_o    (vreg_m_addr_o),
        .vreg_m_data_i    (vreg_m_data_i)
    );

    bind vregunpack_top vregunpack_asserts handshake_asserts_inst (
        .clk_i            (clk_i),
        .async_rst_ni     (async_rst_ni),
        .pipe_in_ready_o  (pipe_in_ready_o),
        .pipe_out_valid_o (pipe_out_valid_o),
        .pipe_out_ready_i (pipe_out_ready_i),
        .pipe_out_resp_o  (pipe_out_resp_o)
    );

    // combinational register file serving both read ports
    assign vreg_a_data_i = regfile[vreg_a_addr_o];
    assign vreg_m_data_i = regfile[vreg_m_addr_o];

    initial clk_i = 1'b0;
    always begin
        #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    always @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            cycle <= '0;
        end else begin
            cycle <= cycle + 32'd1;
        end
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // steps the model buffers like an accepted request and returns the expected response
    function automatic vregunpack_pkg::unpack_resp_t unpack_reference(
        input vregunpack_pkg::unpack_req_t req);
        vregunpack_pkg::unpack_resp_t resp;
        int unsigned a_shift;
        int unsigned m_shift;
        logic [15:0] lo_half;
        logic [15:0] hi_half;
        resp.ctrl = req.ctrl;
        a_shift   = req.a_narrow ? 16 : 32;
        if (req.a_load && req.a_vreg) begin
            ref_a_buf = regfile[req.a_vaddr];
        end else begin
            ref_a_buf = (ref_a_buf >> a_shift) | (ref_a_buf << (128 - a_shift));
        end
        lo_half = req.a_sigext ? 16'($signed(ref_a_buf[7:0])) : {8'h00, ref_a_buf[7:0]};
        hi_half = req.a_sigext ? 16'($signed(ref_a_buf[15:8])) : {8'h00, ref_a_buf[15:8]};
        resp.op_a = ref_a_buf[31:0];
        if (!req.a_vreg) begin
            case (req.eew)
                vregunpack_pkg::VSEW_8:  resp.op_a = {4{req.a_xval[7:0]}};
                vregunpack_pkg::VSEW_16: resp.op_a = {2{req.a_xval[15:0]}};
                default:                 resp.op_a = req.a_xval;
            endcase
        end else if (req.a_narrow && req.eew == vregunpack_pkg::VSEW_16) begin
            resp.op_a = {hi_half, lo_half};
        end else if (req.a_narrow && req.eew == vregunpack_pkg::VSEW_32) begin
            resp.op_a = req.a_sigext ? 32'($signed(ref_a_buf[15:0])) : {16'h0, ref_a_buf[15:0]};
        end
        // one mask bit per element
        case (req.eew)
            vregunpack_pkg::VSEW_16: m_shift = 2;
            vregunpack_pkg::VSEW_32: m_shift = 1;
            default:                 m_shift = 4;
        endcase
        if (req.m_load) begin
            ref_m_buf = regfile[req.m_vaddr];
        end else begin
            ref_m_buf = (ref_m_buf >> m_shift) | (ref_m_buf << (128 - m_shift));
        end
        case (req.eew)
            vregunpack_pkg::VSEW_16: begin
                resp.op_m = {ref_m_buf[1], ref_m_buf[1], ref_m_buf[0], ref_m_buf[0]};
            end
            vregunpack_pkg::VSEW_32: resp.op_m = {4{ref_m_buf[0]}};
            default:                 resp.op_m = ref_m_buf[3:0];
        endcase
        return resp;
    endfunction

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("Errors found");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("FAILED at %0t ns: %s is %0h, expected %0h",
                               $time, name, got, exp));
        end
    endtask

    // hold valid until the DUT takes the request, then idle for gap cycles
    task automatic send(input vregunpack_pkg::unpack_req_t req, input int unsigned gap);
        pipe_in_req_i      = req;
        pipe_in_req_i.ctrl = sent;
        pipe_in_valid_i    = 1'b1;
        @(negedge clk_i);
        while (!pipe_in_ready_o) begin
            @(negedge clk_i);
        end
        @(posedge clk_i);
        #1;
        sent            = sent + 8'd1;
        pipe_in_valid_i = 1'b0;
        repeat (gap) begin
            @(posedge clk_i);
            #1;
        end
    endtask

    task automatic wait_drain();
        while (expected.size() != 0) begin
            @(posedge clk_i);
            #1;
        end
    endtask

    // handshakes and read addresses are sampled mid-cycle before the capturing edge
    always @(negedge clk_i) begin
        expect_t                    exp_e;
        vregunpack_pkg::vreg_addr_t a_addr_exp;
        vregunpack_pkg::vreg_addr_t m_addr_exp;
        a_addr_exp = '0;
        m_addr_exp = '0;
        if (async_rst_ni && pipe_in_valid_i && pipe_in_ready_o) begin
            exp_e.resp      = unpack_reference(pipe_in_req_i);
            exp_e.cycle     = cycle;
            exp_e.check_lat = fixed_ready;
            expected.push_back(exp_e);
            if (pipe_in_req_i.a_load && pipe_in_req_i.a_vreg) begin
                a_addr_exp = pipe_in_req_i.a_vaddr;
            end
            if (pipe_in_req_i.m_load) begin
                m_addr_exp = pipe_in_req_i.m_vaddr;
            end
        end
        if (async_rst_ni) begin
            check_value("vreg_a_addr_o", 32'(vreg_a_addr_o), 32'(a_addr_exp));
            check_value("vreg_m_addr_o", 32'(vreg_m_addr_o), 32'(m_addr_exp));
        end
        if (async_rst_ni && pipe_out_valid_o && pipe_out_ready_i) begin
            if (expected.size() == 0) begin
                fail_run("a response came out with no request outstanding");
            end else begin
                exp_e = expected.pop_front();
                check_value("pipe_out_resp_o.ctrl", 32'(pipe_out_resp_o.ctrl),
                            32'(exp_e.resp.ctrl));
                check_value("pipe_out_resp_o.op_a", pipe_out_resp_o.op_a, exp_e.resp.op_a);
                check_value("pipe_out_resp_o.op_m", 32'(pipe_out_resp_o.op_m),
                            32'(exp_e.resp.op_m));
                if (exp_e.check_lat) begin
                    check_value("response latency", cycle - exp_e.cycle, 32'd2);
                end
            end
        end
    end

    initial begin
        logic [31:0] ready_rnd;
        ready_rnd        = 32'hcb5d_bc3d;
        pipe_out_ready_i = 1'b1;
        forever begin
            @(posedge clk_i);
            #1;
            ready_rnd        = lcg_next(ready_rnd);
            pipe_out_ready_i = random_ready ? ready_rnd[29] | ready_rnd[27] : 1'b1;
        end
    end

    initial begin
        #(CLK_PERIOD * (NUM_REQ * 40 + 16));
        fail_run("watchdog expired before all requests were answered");
    end

    initial begin
        vregunpack_pkg::unpack_req_t req;
        int unsigned gap;
        async_rst_ni    = 1'b0;
        pipe_in_valid_i = 1'b0;
        pipe_in_req_i   = '0;
        random_ready    = 1'b0;
        fixed_ready     = 1'b1;
        sent            = '0;
        ref_a_buf       = '0;
        ref_m_buf       = '0;
        stim_rnd        = 32'hcb5d_bc3d;
        for (int i = 0; i < 32; i++) begin
            for (int j = 0; j < 4; j++) begin
                stim_rnd             = lcg_next(stim_rnd);
                regfile[i][32*j +: 32] = stim_rnd;
            end
        end
        repeat (16) @(posedge clk_i);
        #1;
        async_rst_ni = 1'b1;
        @(posedge clk_i);
        #1;

        // full words of one register from low to high
        req         = '0;
        req.eew     = vregunpack_pkg::VSEW_32;
        req.a_vreg  = 1'b1;
        req.a_load  = 1'b1;
        req.a_vaddr = 5'd3;
        req.m_load  = 1'b1;
        req.m_vaddr = 5'd7;
        send(req, 0);
        req.a_load = 1'b0;
        req.m_load = 1'b0;
        repeat (3) send(req, 0);

        // sign- and zero-extended narrow elements
        for (int e = 1; e <= 2; e++) begin
            for (int s = 0; s < 2; s++) begin
                req          = '0;
                req.eew      = vregunpack_pkg::vsew_t'(e);
                req.a_vreg   = 1'b1;
                req.a_narrow = 1'b1;
                req.a_sigext = s[0];
                req.a_load   = 1'b1;
                req.a_vaddr  = 5'(8 + 2 * e + s);
                send(req, 0);
                req.a_load = 1'b0;
                repeat (3) send(req, 0);
            end
        end

        // X register broadcast
        for (int e = 0; e < 3; e++) begin
            stim_rnd   = lcg_next(stim_rnd);
            req        = '0;
            req.eew    = vregunpack_pkg::vsew_t'(e);
            req.a_xval = stim_rnd;
            send(req, 0);
        end

        // mask expansion at each element width
        for (int e = 0; e < 3; e++) begin
            req         = '0;
            req.eew     = vregunpack_pkg::vsew_t'(e);
            req.a_vreg  = 1'b1;
            req.m_load  = 1'b1;
            req.m_vaddr = 5'(20 + e);
            send(req, 0);
            req.m_load = 1'b0;
            repeat (4) send(req, 0);
        end
        wait_drain();

        // random traffic with gaps and output back-pressure
        fixed_ready  = 1'b0;
        random_ready = 1'b1;
        repeat (NUM_RANDOM) begin
            req          = '0;
            stim_rnd     = lcg_next(stim_rnd);
            req.a_xval   = stim_rnd;
            stim_rnd     = lcg_next(stim_rnd);
            req.eew      = stim_rnd[31:30] % 2'd3;
            req.a_load   = stim_rnd[29];
            req.a_vreg   = stim_rnd[28] | stim_rnd[27];
            req.a_narrow = stim_rnd[26] & (req.eew != vregunpack_pkg::VSEW_8);
            req.a_sigext = stim_rnd[25];
            req.a_vaddr  = stim_rnd[24:20];
            req.m_load   = stim_rnd[19] & stim_rnd[18];
            req.m_vaddr  = stim_rnd[17:13];
            gap          = stim_rnd[12] ? 32'd0 : 32'(stim_rnd[11:10]);
            send(req, gap);
        end
        wait_drain();

        $display("No errors");
        $finish;
    end

endmodule

// ==== sim/vregunpack_asserts.sv ====
`timescale 1ns/100ps
// handshake checks for the vregunpack top level
// a stalled response holds, and the input stays open while the output drains
module vregunpack_asserts (
    input logic                         clk_i,
    input logic                         async_rst_ni,
    input logic                         pipe_in_ready_o,
    input logic                         pipe_out_valid_o,
    input logic                         pipe_out_ready_i,
    input vregunpack_pkg::unpack_resp_t pipe_out_resp_o
);

    // stalled output keeps valid and the response unchanged
    stall_holds_response: assert property (
        @(posedge clk_i) disable iff (!async_rst_ni)
        pipe_out_valid_o && !pipe_out_ready_i |=> pipe_out_valid_o && $stable(pipe_out_resp_o)
    ) else $error("stalled response changed or lost valid");

    ready_out_opens_input: assert property (
        @(posedge clk_i) disable iff (!async_rst_ni)
        pipe_out_ready_i |-> pipe_in_ready_o
    ) else $error("input not ready while the output is ready");

    // an empty output stage always leaves room for a new request
    empty_out_opens_input: assert property (
        @(posedge clk_i) disable iff (!async_rst_ni)
        !pipe_out_valid_o |-> pipe_in_ready_o
    ) else $error("input not ready while the output stage is empty");

endmodule

// ==== rtl/vregunpack_top.sv ====
`timescale 1ns/100ps
// vregunpack top level
// two-stage unpack pipeline joining the stage control with the element
// and mask operand units
module vregunpack_top (
    input  logic                         clk_i,
    input  logic                         async_rst_ni,
    input  logic                         pipe_in_valid_i,
    output logic                         pipe_in_ready_o,
    input  vregunpack_pkg::unpack_req_t  pipe_in_req_i,
    output logic                         pipe_out_valid_o,
    input  logic                         pipe_out_ready_i,
    output vregunpack_pkg::unpack_resp_t pipe_out_resp_o,
    output vregunpack_pkg::vreg_addr_t   vreg_a_addr_o,
    input  vregunpack_pkg::vreg_data_t   vreg_a_data_i,
    output vregunpack_pkg::vreg_addr_t   vreg_m_addr_o,
    input  vregunpack_pkg::vreg_data_t   vreg_m_data_i
);

    logic                     adv1;
    logic                     adv2;
    vregunpack_pkg::vsew_t    eew_s1;
    vregunpack_pkg::ctrl_t    ctrl_out;
    vregunpack_pkg::operand_t op_a;
    vregunpack_pkg::mask_op_t op_m;

    unpack_stage_ctrl stage_ctrl_inst (
        .clk_i            (clk_i),
        .async_rst_ni     (async_rst_ni),
        .pipe_in_valid_i  (pipe_in_valid_i),
        .pipe_in_ctrl_i   (pipe_in_req_i.ctrl),
        .pipe_in_eew_i    (pipe_in_req_i.eew),
        .pipe_out_ready_i (pipe_out_ready_i),
        .pipe_in_ready_o  (pipe_in_ready_o),
        .pipe_out_valid_o (pipe_out_valid_o),
        .adv1_o           (adv1),
        .adv2_o           (adv2),
        .eew_s1_o         (eew_s1),
        .ctrl_o           (ctrl_out)
    );

    elem_operand_unpack elem_unpack_inst (
        .clk_i        (clk_i),
        .async_rst_ni (async_rst_ni),
        .in_valid_i   (pipe_in_valid_i),
        .req_i        (pipe_in_req_i),
        .adv1_i       (adv1),
        .adv2_i       (adv2),
        .eew_s1_i     (eew_s1),
        .vreg_addr_o  (vreg_a_addr_o),
        .vreg_data_i  (vreg_a_data_i),
        .op_o         (op_a)
    );

    mask_operand_unpack mask_unpack_inst (
        .clk_i        (clk_i),
        .async_rst_ni (async_rst_ni),
        .in_valid_i   (pipe_in_valid_i),
        .req_i        (pipe_in_req_i),
        .adv1_i       (adv1),
        .adv2_i       (adv2),
        .eew_s1_i     (eew_s1),
        .vreg_addr_o  (vreg_m_addr_o),
        .vreg_data_i  (vreg_m_data_i),
        .op_o         (op_m)
    );

    assign pipe_out_resp_o.ctrl = ctrl_out;
    assign pipe_out_resp_o.op_a = op_a;
    assign pipe_out_resp_o.op_m = op_m;

endmodule

// ==== rtl/mask_operand_unpack.sv ====
`timescale 1ns/100ps
// mask operand unpack
// reads operand M into a cyclic buffer and expands the element mask
// into a byte mask for the output stage
module mask_operand_unpack (
    input  logic                        clk_i,
    input  logic                        async_rst_ni,
    input  logic                        in_valid_i,
    input  vregunpack_pkg::unpack_req_t req_i,
    input  logic                        adv1_i,
    input  logic                        adv2_i,
    input  vregunpack_pkg::vsew_t       eew_s1_i,
    output vregunpack_pkg::vreg_addr_t  vreg_addr_o,
    input  vregunpack_pkg::vreg_data_t  vreg_data_i,
    output vregunpack_pkg::mask_op_t    op_o
);

    logic                       enter;
    logic [2:0]                 shamt;
    vregunpack_pkg::vreg_data_t buffer_q;
    vregunpack_pkg::vreg_data_t buffer_d;
    logic [2*vregunpack_pkg::VREG_DATA_W-1:0] buffer_dbl;

    vregunpack_pkg::mask_op_t op_d;
    vregunpack_pkg::mask_op_t op_q;

    assign enter       = in_valid_i & adv1_i;
    assign vreg_addr_o = (enter & req_i.m_load) ? req_i.m_vaddr : '0;

    // mask bits consumed by one request, one per element
    always_comb begin
        case (req_i.eew)
            vregunpack_pkg::VSEW_16: shamt = 3'd2;
            vregunpack_pkg::VSEW_32: shamt = 3'd1;
            default:                 shamt = 3'd4;
        endcase
    end

    assign buffer_dbl = {buffer_q, buffer_q};
    assign buffer_d   = req_i.m_load ? vreg_data_i
                                     : buffer_dbl[shamt +: vregunpack_pkg::VREG_DATA_W];

    always_ff @(posedge clk_i) begin
        if (enter) begin
            buffer_q <= buffer_d;
        end
    end

    // element mask to byte mask
    always_comb begin
        case (eew_s1_i)
            vregunpack_pkg::VSEW_16: op_d = {{2{buffer_q[1]}}, {2{buffer_q[0]}}};
            vregunpack_pkg::VSEW_32: op_d = {4{buffer_q[0]}};
            default:                 op_d = buffer_q[vregunpack_pkg::MASK_OP_W-1:0];
        endcase
    end

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            op_q <= '0;
        end else if (adv2_i) begin
            op_q <= op_d;
        end
    end

    assign op_o = op_q;

endmodule

// ==== rtl/elem_operand_unpack.sv ====
`timescale 1ns/100ps
// element operand unpack
// reads operand A into a cyclic buffer, extracts full, narrow or
// X-register elements and registers the result for the output stage
module elem_operand_unpack (
    input  logic                        clk_i,
    input  logic                        async_rst_ni,
    input  logic                        in_valid_i,
    input  vregunpack_pkg::unpack_req_t req_i,
    input  logic                        adv1_i,
    input  logic                        adv2_i,
    input  vregunpack_pkg::vsew_t       eew_s1_i,
    output vregunpack_pkg::vreg_addr_t  vreg_addr_o,
    input  vregunpack_pkg::vreg_data_t  vreg_data_i,
    output vregunpack_pkg::operand_t    op_o
);

    logic                       enter;
    logic                       load;
    vregunpack_pkg::vreg_data_t buffer_q;
    vregunpack_pkg::vreg_data_t buffer_d;
    logic [2*vregunpack_pkg::VREG_DATA_W-1:0] buffer_dbl;

    // stage 1 flags of the request owning the buffer
    logic                  narrow_q;
    logic                  sigext_q;
    logic                  vreg_q;
    vregunpack_pkg::xval_t xval_q;

    vregunpack_pkg::operand_t op_d;
    vregunpack_pkg::operand_t op_q;

    // valid request moving into stage 1
    assign enter = in_valid_i & adv1_i;
    // an X-register operand never touches the register file
    assign load  = req_i.a_load & req_i.a_vreg;

    assign vreg_addr_o = (enter & load) ? req_i.a_vaddr : '0;

    // doubled copy turns the shift into a rotation
    assign buffer_dbl = {buffer_q, buffer_q};

    always_comb begin
        if (load) begin
            buffer_d = vreg_data_i;
        end else if (req_i.a_narrow) begin
            buffer_d = buffer_dbl[vregunpack_pkg::OPERAND_W/2 +: vregunpack_pkg::VREG_DATA_W];
        end else begin
            buffer_d = buffer_dbl[vregunpack_pkg::OPERAND_W +: vregunpack_pkg::VREG_DATA_W];
        end
    end

    always_ff @(posedge clk_i) begin
        if (enter) begin
            buffer_q <= buffer_d;
        end
        if (adv1_i) begin
            xval_q <= req_i.a_xval;
        end
    end

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            narrow_q <= 1'b0;
            sigext_q <= 1'b0;
            vreg_q   <= 1'b1;
            op_q     <= '0;
        end else begin
            if (adv1_i) begin
                narrow_q <= req_i.a_narrow;
                sigext_q <= req_i.a_sigext;
                vreg_q   <= req_i.a_vreg;
            end
            if (adv2_i) begin
                op_q <= op_d;
            end
        end
    end

    // extraction from the low end of the buffer
    always_comb begin
        op_d = buffer_q[vregunpack_pkg::OPERAND_W-1:0];
        if (!vreg_q) begin
            // scalar broadcast at the element width
            case (eew_s1_i)
                vregunpack_pkg::VSEW_8:  op_d = {4{xval_q[7:0]}};
                vregunpack_pkg::VSEW_16: op_d = {2{xval_q[15:0]}};
                default:                 op_d = xval_q;
            endcase
        end else if (narrow_q) begin
            // each narrow element grows to twice its size
            case (eew_s1_i)
                vregunpack_pkg::VSEW_16: begin
                    op_d = {{8{sigext_q & buffer_q[15]}}, buffer_q[15:8],
                            {8{sigext_q & buffer_q[7]}}, buffer_q[7:0]};
                end
                vregunpack_pkg::VSEW_32: begin
                    op_d = {{16{sigext_q & buffer_q[15]}}, buffer_q[15:0]};
                end
                default: ;
            endcase
        end
    end

    assign op_o = op_q;

endmodule

// ==== rtl/unpack_stage_ctrl.sv ====
`timescale 1ns/100ps
// unpack stage control
// keeps the per-stage valid bits with the control and element-width stage
// registers, and derives the advance signals of both stages
module unpack_stage_ctrl (
    input  logic                  clk_i,
    input  logic                  async_rst_ni,
    input  logic                  pipe_in_valid_i,
    input  vregunpack_pkg::ctrl_t pipe_in_ctrl_i,
    input  vregunpack_pkg::vsew_t pipe_in_eew_i,
    input  logic                  pipe_out_ready_i,
    output logic                  pipe_in_ready_o,
    output logic                  pipe_out_valid_o,
    output logic                  adv1_o,
    output logic                  adv2_o,
    output vregunpack_pkg::vsew_t eew_s1_o,
    output vregunpack_pkg::ctrl_t ctrl_o
);

    // bit 0 belongs to stage 1, the top bit to the output stage
    logic [vregunpack_pkg::UNPACK_STAGES-1:0] valid_q;
    logic [vregunpack_pkg::UNPACK_STAGES-1:0] adv;

    vregunpack_pkg::ctrl_t ctrl_s1_q;
    vregunpack_pkg::ctrl_t ctrl_s2_q;
    vregunpack_pkg::vsew_t eew_s1_q;

    // no stage stalls on its own, so a stage captures when the output
    // drains or any stage from it onward is empty
    always_comb begin
        adv = '0;
        for (int i = 0; i < vregunpack_pkg::UNPACK_STAGES; i++) begin
            adv[i] = pipe_out_ready_i;
            for (int j = i; j < vregunpack_pkg::UNPACK_STAGES; j++) begin
                if (!valid_q[j]) begin
                    adv[i] = 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            valid_q <= '0;
        end else begin
            if (adv[0]) begin
                valid_q[0] <= pipe_in_valid_i;
            end
            for (int i = 1; i < vregunpack_pkg::UNPACK_STAGES; i++) begin
                if (adv[i]) begin
                    valid_q[i] <= valid_q[i-1];
                end
            end
        end
    end

    // control word and element width follow the valid bits
    always_ff @(posedge clk_i) begin
        if (adv[0]) begin
            ctrl_s1_q <= pipe_in_ctrl_i;
            eew_s1_q  <= pipe_in_eew_i;
        end
        if (adv[1]) begin
            ctrl_s2_q <= ctrl_s1_q;
        end
    end

    assign pipe_in_ready_o  = adv[0];
    assign pipe_out_valid_o = valid_q[vregunpack_pkg::UNPACK_STAGES-1];
    assign adv1_o           = adv[0];
    assign adv2_o           = adv[1];
    assign eew_s1_o         = eew_s1_q;
    assign ctrl_o           = ctrl_s2_q;

endmodule

// ==== rtl/vregunpack_pkg.sv ====
// vregunpack shared definitions
// widths, element-width codes and the pipeline request/response structs
package vregunpack_pkg;

    // number of unpack stages between input and output
    localparam int unsigned UNPACK_STAGES = 2;

    localparam int unsigned VREG_ADDR_W = 5;
    localparam int unsigned VREG_DATA_W = 128;
    localparam int unsigned OPERAND_W   = 32;
    // one mask bit per operand byte
    localparam int unsigned MASK_OP_W   = OPERAND_W / 8;
    localparam int unsigned CTRL_W      = 8;

    typedef logic [VREG_ADDR_W-1:0] vreg_addr_t;
    typedef logic [VREG_DATA_W-1:0] vreg_data_t;
    typedef logic [OPERAND_W-1:0]   operand_t;
    typedef logic [MASK_OP_W-1:0]   mask_op_t;
    typedef logic [31:0]            xval_t;
    typedef logic [CTRL_W-1:0]      ctrl_t;
    typedef logic [1:0]             vsew_t;

    // element width codes, 3 is unused
    localparam vsew_t VSEW_8  = 2'd0;
    localparam vsew_t VSEW_16 = 2'd1;
    localparam vsew_t VSEW_32 = 2'd2;

    typedef struct packed {
        ctrl_t      ctrl;
        vsew_t      eew;
        logic       a_load;
        vreg_addr_t a_vaddr;
        logic       a_vreg;
        logic       a_narrow;
        logic       a_sigext;
        xval_t      a_xval;
        logic       m_load;
        vreg_addr_t m_vaddr;
    } unpack_req_t;

    typedef struct packed {
        ctrl_t    ctrl;
        operand_t op_a;
        mask_op_t op_m;
    } unpack_resp_t;

endpackage
